//--- hw/axil_pkg.sv
package axil_pkg;

   // Response codes used by the RAM slave
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axil_resp_t;

   // Unprivileged, non-secure, data access
   localparam logic [2:0] AXIL_PROT_DATA = 3'b010;

   // Slave sequencing
   typedef enum logic [1:0] {
      RAM_IDLE = 2'd0,
      RAM_WAIT = 2'd1,  // Wait states running
      RAM_RESP = 2'd2   // bvalid or rvalid held
   } ram_state_t;

endpackage

//--- hw/iob_pkg.sv
package iob_pkg;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } iob_op_t;

   typedef enum logic [2:0] {
      BR_IDLE    = 3'd0,
      BR_WR_REQ  = 3'd1,  // aw and w channels open
      BR_WR_RESP = 3'd2,
      BR_RD_REQ  = 3'd3,
      BR_RD_DATA = 3'd4,
      BR_DONE    = 3'd5   // Native ready pulse
   } bridge_state_t;

endpackage

//--- hw/axil_if.sv
`timescale 1ns/1ns

interface axil_if import axil_pkg::*; #(
   parameter int AXIL_ADDR_W = 32,
   parameter int AXIL_DATA_W = 32
) ();

   logic [AXIL_ADDR_W-1:0]   awaddr;
   logic [2:0]               awprot;
   logic                     awvalid;
   logic                     awready;

   logic [AXIL_DATA_W-1:0]   wdata;
   logic [AXIL_DATA_W/8-1:0] wstrb;
   logic                     wvalid;
   logic                     wready;

   axil_resp_t               bresp;
   logic                     bvalid;
   logic                     bready;

   logic [AXIL_ADDR_W-1:0]   araddr;
   logic [2:0]               arprot;
   logic                     arvalid;
   logic                     arready;

   logic [AXIL_DATA_W-1:0]   rdata;
   axil_resp_t               rresp;
   logic                     rvalid;
   logic                     rready;

   modport master (
      output awaddr, awprot, awvalid, input awready,
      output wdata, wstrb, wvalid, input wready,
      input  bresp, bvalid, output bready,
      output araddr, arprot, arvalid, input arready,
      input  rdata, rresp, rvalid, output rready
   );

   modport slave (
      input  awaddr, awprot, awvalid, output awready,
      input  wdata, wstrb, wvalid, output wready,
      output bresp, bvalid, input bready,
      input  araddr, arprot, arvalid, output arready,
      output rdata, rresp, rvalid, input rready
   );

endinterface

//--- hw/iob2axil_fsm.sv
`timescale 1ns/1ns

module iob2axil_fsm import iob_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    req,
   input  iob_op_t op,
   input  logic    awready,
   input  logic    wready,
   input  logic    bvalid,
   input  logic    arready,
   input  logic    rvalid,
   output logic    accept,
   output logic    awvalid,
   output logic    wvalid,
   output logic    bready,
   output logic    arvalid,
   output logic    rready,
   output logic    capture,
   output logic    done
);

   bridge_state_t state;
   bridge_state_t state_nxt;
   logic          aw_done;  // aw handshake already seen
   logic          w_done;
   logic          aw_hs;
   logic          w_hs;

   assign aw_hs = awvalid & awready;
   assign w_hs  = wvalid & wready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= BR_IDLE;
         aw_done <= 1'b0;
         w_done  <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state_nxt == BR_WR_REQ) begin
            aw_done <= aw_done | aw_hs;
            w_done  <= w_done | w_hs;
         end else begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
         end
      end
   end

   always_comb begin
      state_nxt = state;
      accept    = 1'b0;
      awvalid   = 1'b0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      capture   = 1'b0;
      done      = 1'b0;
      case (state)
         BR_IDLE: begin
            accept = req;
            if (req) begin
               if (op == OP_WRITE) state_nxt = BR_WR_REQ;
               else state_nxt = BR_RD_REQ;
            end
         end
         BR_WR_REQ: begin
            awvalid = ~aw_done;
            wvalid  = ~w_done;
            // Either channel may finish first
            if ((aw_done | aw_hs) & (w_done | w_hs)) state_nxt = BR_WR_RESP;
         end
         BR_WR_RESP: begin
            bready = 1'b1;
            if (bvalid) begin
               capture   = 1'b1;
               state_nxt = BR_DONE;
            end
         end
         BR_RD_REQ: begin
            arvalid = 1'b1;
            if (arready) state_nxt = BR_RD_DATA;
         end
         BR_RD_DATA: begin
            rready = 1'b1;
            if (rvalid) begin
               capture   = 1'b1;
               state_nxt = BR_DONE;
            end
         end
         BR_DONE: begin
            done      = 1'b1;
            state_nxt = BR_IDLE;
         end
         default: state_nxt = BR_IDLE;
      endcase
   end

   // Request valids hold until the slave takes them
   assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid);
   assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid);
   assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid);

   assert property (@(posedge clk) disable iff (rst)
      accept |-> (state == BR_IDLE) ##1 (state inside {BR_WR_REQ, BR_RD_REQ}));

endmodule

//--- hw/iob2axil.sv
`timescale 1ns/1ns

module iob2axil import axil_pkg::*, iob_pkg::*; #(
   parameter int AXIL_ADDR_W = 32,
   parameter int AXIL_DATA_W = 32
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     valid,
   input  logic [AXIL_ADDR_W-1:0]   addr,
   input  logic [AXIL_DATA_W-1:0]   wdata,
   input  logic [AXIL_DATA_W/8-1:0] wstrb,
   output logic [AXIL_DATA_W-1:0]   rdata,
   output logic                     ready,
   output logic                     err,
   axil_if.master                   axil
);

   iob_op_t                  op;
   iob_op_t                  op_q;
   axil_resp_t               resp;
   logic                     accept;
   logic                     capture;
   logic [AXIL_ADDR_W-1:0]   addr_q;
   logic [AXIL_DATA_W-1:0]   wdata_q;
   logic [AXIL_DATA_W/8-1:0] wstrb_q;

   // Any strobe bit set means write
   always_comb begin
      if (|wstrb) op = OP_WRITE;
      else op = OP_READ;
   end

   always_comb begin
      if (op_q == OP_WRITE) resp = axil.bresp;
      else resp = axil.rresp;
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= addr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op_q  <= OP_READ;
         rdata <= '0;
         err   <= 1'b0;
      end else begin
         if (accept) op_q <= op;
         if (capture) begin
            err <= (resp == RESP_SLVERR);
            if (op_q == OP_READ) rdata <= axil.rdata;  // Held until next read
         end
      end
   end

   assign axil.awaddr = addr_q;
   assign axil.araddr = addr_q;
   assign axil.awprot = AXIL_PROT_DATA;
   assign axil.arprot = AXIL_PROT_DATA;
   assign axil.wdata  = wdata_q;
   assign axil.wstrb  = wstrb_q;

   iob2axil_fsm fsm_inst (
      .clk     (clk),
      .rst     (rst),
      .req     (valid),
      .op      (op),
      .awready (axil.awready),
      .wready  (axil.wready),
      .bvalid  (axil.bvalid),
      .arready (axil.arready),
      .rvalid  (axil.rvalid),
      .accept  (accept),
      .awvalid (axil.awvalid),
      .wvalid  (axil.wvalid),
      .bready  (axil.bready),
      .arvalid (axil.arvalid),
      .rready  (axil.rready),
      .capture (capture),
      .done    (ready)
   );

endmodule

//--- hw/axil_wait_timer.sv
`timescale 1ns/1ns

module axil_wait_timer #(
   parameter int WAIT_CYCLES = 2
) (
   input  logic clk,
   input  logic rst,
   input  logic start,
   output logic busy,
   output logic done
);

   // At least one bit, also for zero wait states
   localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt  <= '0;
         busy <= 1'b0;
      end else if (start) begin
         cnt  <= CNT_W'(WAIT_CYCLES);
         busy <= 1'b1;
      end else if (busy) begin
         if (cnt == '0) busy <= 1'b0;  // Last cycle is the done cycle
         else cnt <= cnt - 1'b1;
      end
   end

   assign done = busy && (cnt == '0);

   assert property (@(posedge clk) disable iff (rst) start |-> !busy);

   // Fixed latency seen by the slave
   assert property (@(posedge clk) disable iff (rst) start |-> ##(WAIT_CYCLES + 1) done);

endmodule

//--- hw/axil_ram.sv
`timescale 1ns/1ns

module axil_ram import axil_pkg::*; #(
   parameter int AXIL_ADDR_W = 32,
   parameter int AXIL_DATA_W = 32,
   parameter int RAM_DEPTH   = 64,
   parameter int WAIT_CYCLES = 2
) (
   input logic   clk,
   input logic   rst,
   axil_if.slave axil
);

   localparam int STRB_W = AXIL_DATA_W / 8;
   localparam int OFFS_W = $clog2(STRB_W);
   localparam int IDX_W  = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

   ram_state_t                    state;
   logic                          is_wr;  // Access in flight is a write
   logic                          start;
   logic                          busy;
   logic                          done;
   logic                          fire;   // Handshake and access this cycle
   logic [AXIL_ADDR_W-1:0]        acc_addr;
   logic [AXIL_ADDR_W-OFFS_W-1:0] word;
   logic                          in_range;
   logic [IDX_W-1:0]              idx;
   logic [AXIL_DATA_W-1:0]        mem [RAM_DEPTH];

   assign start = (state == RAM_IDLE) && ((axil.awvalid && axil.wvalid) || axil.arvalid);
   assign fire  = (state == RAM_WAIT) && done;

   // Address stays stable until ready, so the live one is used
   assign acc_addr = is_wr ? axil.awaddr : axil.araddr;
   assign word     = acc_addr[AXIL_ADDR_W-1:OFFS_W];
   assign in_range = word < RAM_DEPTH;
   assign idx      = word[IDX_W-1:0];

   assign axil.awready = fire && is_wr;
   assign axil.wready  = fire && is_wr;
   assign axil.arready = fire && !is_wr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= RAM_IDLE;
         is_wr       <= 1'b0;
         axil.bvalid <= 1'b0;
         axil.rvalid <= 1'b0;
      end else begin
         case (state)
            RAM_IDLE: begin
               if (start) begin
                  is_wr <= axil.awvalid && axil.wvalid;  // Write wins
                  state <= RAM_WAIT;
               end
            end
            RAM_WAIT: begin
               if (done) begin
                  axil.bvalid <= is_wr;
                  axil.rvalid <= !is_wr;
                  state       <= RAM_RESP;
               end
            end
            RAM_RESP: begin
               if ((axil.bvalid && axil.bready) || (axil.rvalid && axil.rready)) begin
                  axil.bvalid <= 1'b0;
                  axil.rvalid <= 1'b0;
                  state       <= RAM_IDLE;
               end
            end
            default: state <= RAM_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         if (in_range) begin
            axil.bresp <= RESP_OKAY;
            axil.rresp <= RESP_OKAY;
         end else begin
            axil.bresp <= RESP_SLVERR;
            axil.rresp <= RESP_SLVERR;
         end
         if (!is_wr) begin
            if (in_range) axil.rdata <= mem[idx];
            else axil.rdata <= '0;
         end
         if (is_wr && in_range) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (axil.wstrb[b]) mem[idx][8*b +: 8] <= axil.wdata[8*b +: 8];
            end
         end
      end
   end

   axil_wait_timer #(
      .WAIT_CYCLES (WAIT_CYCLES)
   ) timer_inst (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .busy  (busy),
      .done  (done)
   );

   // Responses hold until the master takes them
   assert property (@(posedge clk) disable iff (rst) axil.bvalid && !axil.bready |=> axil.bvalid);
   assert property (@(posedge clk) disable iff (rst) axil.rvalid && !axil.rready |=> axil.rvalid);

   assert property (@(posedge clk) disable iff (rst) (state == RAM_WAIT) |-> busy);

endmodule

//--- hw/iob_axil_sys.sv
`timescale 1ns/1ns

module iob_axil_sys #(
   parameter int AXIL_ADDR_W = 32,
   parameter int AXIL_DATA_W = 32,
   parameter int RAM_DEPTH   = 64,
   parameter int WAIT_CYCLES = 2
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     valid,
   input  logic [AXIL_ADDR_W-1:0]   addr,
   input  logic [AXIL_DATA_W-1:0]   wdata,
   input  logic [AXIL_DATA_W/8-1:0] wstrb,
   output logic [AXIL_DATA_W-1:0]   rdata,
   output logic                     ready,
   output logic                     err
);

   axil_if #(
      .AXIL_ADDR_W (AXIL_ADDR_W),
      .AXIL_DATA_W (AXIL_DATA_W)
   ) axil_if_inst ();

   iob2axil #(
      .AXIL_ADDR_W (AXIL_ADDR_W),
      .AXIL_DATA_W (AXIL_DATA_W)
   ) iob2axil_inst (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .addr  (addr),
      .wdata (wdata),
      .wstrb (wstrb),
      .rdata (rdata),
      .ready (ready),
      .err   (err),
      .axil  (axil_if_inst.master)
   );

   axil_ram #(
      .AXIL_ADDR_W (AXIL_ADDR_W),
      .AXIL_DATA_W (AXIL_DATA_W),
      .RAM_DEPTH   (RAM_DEPTH),
      .WAIT_CYCLES (WAIT_CYCLES)
   ) axil_ram_inst (
      .clk  (clk),
      .rst  (rst),
      .axil (axil_if_inst.slave)
   );

endmodule

//--- verif/iob_axil_sys_tb.sv
`timescale 1ns/1ns

module iob_axil_sys_tb import iob_pkg::*;;

   localparam int AXIL_ADDR_W = 32;
   localparam int AXIL_DATA_W = 32;
   localparam int RAM_DEPTH   = 64;
   localparam int WAIT_CYCLES = 2;
   localparam int CLK_PERIOD  = 4;
   localparam int RST_CYCLES  = 10;
   localparam int MAX_ENTRIES = 64;
   localparam int NUM_RANDOM  = 40;

   logic                     clk;
   logic                     rst;
   logic                     valid;
   logic [AXIL_ADDR_W-1:0]   addr;
   logic [AXIL_DATA_W-1:0]   wdata;
   logic [AXIL_DATA_W/8-1:0] wstrb;
   logic [AXIL_DATA_W-1:0]   rdata;
   logic                     ready;
   logic                     err;

   // Stimulus table
   string       tab_name  [MAX_ENTRIES];
   iob_op_t     tab_op    [MAX_ENTRIES];
   logic [31:0] tab_addr  [MAX_ENTRIES];
   logic [31:0] tab_wdata [MAX_ENTRIES];
   logic [3:0]  tab_wstrb [MAX_ENTRIES];
   logic [31:0] tab_rdata [MAX_ENTRIES];
   logic        tab_err   [MAX_ENTRIES];
   int          num_entries = 0;
   bit          table_built = 1'b0;

   logic [31:0] model_mem [RAM_DEPTH];  // Starts unknown, like the RAM
   integer      seed;

   iob_axil_sys #(
      .AXIL_ADDR_W (AXIL_ADDR_W),
      .AXIL_DATA_W (AXIL_DATA_W),
      .RAM_DEPTH   (RAM_DEPTH),
      .WAIT_CYCLES (WAIT_CYCLES)
   ) iob_axil_sys_inst (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .addr  (addr),
      .wdata (wdata),
      .wstrb (wstrb),
      .rdata (rdata),
      .ready (ready),
      .err   (err)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic bit addr_ok(input logic [31:0] a);
      return (a >> 2) < RAM_DEPTH;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Fail %s expected %h actual %h", name, expected, actual);
         $display("TESTS FAILED");
         $fatal(1);
      end
   endtask

   // Appends one entry and applies writes to the memory model
   task automatic push_entry(input string name, input iob_op_t op, input logic [31:0] a,
                             input logic [31:0] d, input logic [3:0] s,
                             input logic [31:0] exp_rd, input logic exp_e);
      tab_name[num_entries]  = name;
      tab_op[num_entries]    = op;
      tab_addr[num_entries]  = a;
      tab_wdata[num_entries] = d;
      tab_wstrb[num_entries] = (op == OP_WRITE) ? s : 4'h0;
      tab_rdata[num_entries] = exp_rd;
      tab_err[num_entries]   = exp_e;
      num_entries++;
      if (op == OP_WRITE && addr_ok(a)) begin
         for (int b = 0; b < 4; b++) begin
            if (s[b]) model_mem[a >> 2][8*b +: 8] = d[8*b +: 8];
         end
      end
   endtask

   task automatic build_random_entries(input int count);
      int          word;
      logic [31:0] a;
      logic [31:0] d;
      logic [3:0]  s;
      bit          is_wr;
      logic [31:0] exp_rd;
      for (int i = 0; i < count; i++) begin
         if ({$random(seed)} % 5 == 0) word = RAM_DEPTH + {$random(seed)} % 64;
         else word = {$random(seed)} % 8;  // Small window so reads hit written words
         a     = 32'(word * 4) + ({$random(seed)} % 4);
         d     = $random(seed);
         s     = 4'($random(seed));
         is_wr = 1'({$random(seed)} % 2);
         // Unknown words are filled before they are read
         if (!is_wr && addr_ok(a) && (^model_mem[a >> 2] === 1'bx)) begin
            is_wr = 1'b1;
            s     = 4'hF;
         end
         if (is_wr && s == 4'h0) s = 4'hF;
         if (!is_wr && addr_ok(a)) exp_rd = model_mem[a >> 2];
         else exp_rd = 32'h0;
         push_entry($sformatf("rand_%0d", i), is_wr ? OP_WRITE : OP_READ, a, d, s,
                    exp_rd, !addr_ok(a));
      end
   endtask

   initial begin
      clk   = 1'b0;
      rst   = 1'b1;
      valid = 1'b0;
      addr  = '0;
      wdata = '0;
      wstrb = '0;
      seed  = 32'h10d81448;

      push_entry("wr_full_w0", OP_WRITE, 32'h0000_0000, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b0);
      push_entry("rd_full_w0", OP_READ, 32'h0000_0000, 32'h0, 4'h0, 32'hDEAD_BEEF, 1'b0);
      push_entry("wr_full_w5", OP_WRITE, 32'h0000_0014, 32'h1234_5678, 4'hF, 32'h0, 1'b0);
      push_entry("wr_part_b0", OP_WRITE, 32'h0000_0014, 32'hAAAA_AAAA, 4'b0001, 32'h0, 1'b0);
      push_entry("wr_part_b2", OP_WRITE, 32'h0000_0016, 32'h55CC_55CC, 4'b0100, 32'h0, 1'b0);
      push_entry("rd_part_w5", OP_READ, 32'h0000_0014, 32'h0, 4'h0, 32'h12CC_56AA, 1'b0);
      push_entry("wr_part_b31", OP_WRITE, 32'h0000_0014, 32'hBE00_EF00, 4'b1010, 32'h0, 1'b0);
      push_entry("rd_part_w5b", OP_READ, 32'h0000_0014, 32'h0, 4'h0, 32'hBECC_EFAA, 1'b0);
      push_entry("wr_last_w63", OP_WRITE, 32'h0000_00FC, 32'hCAFE_F00D, 4'hF, 32'h0, 1'b0);
      push_entry("rd_last_w63", OP_READ, 32'h0000_00FC, 32'h0, 4'h0, 32'hCAFE_F00D, 1'b0);
      // Word 64 aliases word 0 in the low index bits
      push_entry("wr_oor_w64", OP_WRITE, 32'h0000_0100, 32'hFFFF_FFFF, 4'hF, 32'h0, 1'b1);
      push_entry("rd_oor_w64", OP_READ, 32'h0000_0100, 32'h0, 4'h0, 32'h0, 1'b1);
      push_entry("wr_oor_top", OP_WRITE, 32'hFFFF_FFF0, 32'h0BAD_0BAD, 4'hF, 32'h0, 1'b1);
      push_entry("rd_oor_top", OP_READ, 32'hFFFF_FFFC, 32'h0, 4'h0, 32'h0, 1'b1);
      push_entry("rd_w0_after", OP_READ, 32'h0000_0000, 32'h0, 4'h0, 32'hDEAD_BEEF, 1'b0);
      build_random_entries(NUM_RANDOM);
      table_built = 1'b1;

      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;

      @(negedge clk);
      check_value("reset_ready", 32'h0, 32'(ready));
      check_value("reset_err", 32'h0, 32'(err));
      check_value("reset_rdata", 32'h0, rdata);

      // Each request starts in the cycle after the previous ready
      for (int i = 0; i < num_entries; i++) begin
         @(posedge clk);
         valid <= 1'b1;
         addr  <= tab_addr[i];
         wdata <= tab_wdata[i];
         wstrb <= tab_wstrb[i];
         @(negedge clk);
         while (!ready) @(negedge clk);
         if (tab_op[i] == OP_READ) check_value({tab_name[i], " rdata"}, tab_rdata[i], rdata);
         check_value({tab_name[i], " err"}, 32'(tab_err[i]), 32'(err));
      end
      @(posedge clk);
      valid <= 1'b0;
      wstrb <= '0;
      repeat (2) @(posedge clk);

      $display("TESTS PASSED");
      $finish;
   end

   initial begin
      wait (table_built);
      #((num_entries * (WAIT_CYCLES + 12) + RST_CYCLES) * CLK_PERIOD);
      $display("Watchdog expired, ready never arrived for a pending request");
      $display("TESTS FAILED");
      $fatal(1);
   end

endmodule

//--- filelist.f
hw/axil_pkg.sv
hw/iob_pkg.sv
hw/axil_if.sv
hw/iob2axil_fsm.sv
hw/iob2axil.sv
hw/axil_wait_timer.sv
hw/axil_ram.sv
hw/iob_axil_sys.sv
verif/iob_axil_sys_tb.sv
